/* dv/overlay_assertions.sv */
`include "overlay_config.svh"

module overlay_assertions (
    input logic                        clk,
    input logic                        reset,
    input logic                        vsync_i,
    input overlay_pkg::region_coords_t region_min_x_i,
    input overlay_pkg::region_coords_t region_max_x_i,
    input overlay_pkg::region_coords_t region_min_y_i,
    input overlay_pkg::region_coords_t region_max_y_i,
    input overlay_pkg::coord_t         draw_x_i,
    input overlay_pkg::coord_t         draw_y_i,
    input logic [`OVL_PIX_W-1:0]       pixel_i,
    input overlay_pkg::shade_t         brightness_i,
    input logic [`OVL_THRESH_W-1:0]    area_thresh_i,
    input logic                        highlight_i,
    input overlay_pkg::shade_t         red_o,
    input overlay_pkg::shade_t         green_o,
    input overlay_pkg::shade_t         blue_o
);

    localparam overlay_pkg::shade_t FULL_SHADE = 7'h7F;

    logic                        vs_meta;
    logic                        vs_sync;
    logic                        vs_last;
    logic                        end_of_vsync;
    int unsigned                 event_count;
    logic                        snap_taken;
    overlay_pkg::region_coords_t ref_min_x;
    overlay_pkg::region_coords_t ref_max_x;
    overlay_pkg::region_coords_t ref_min_y;
    overlay_pkg::region_coords_t ref_max_y;
    overlay_pkg::region_mask_t   ref_valid;
    overlay_pkg::region_mask_t   valid_next;
    logic                        hit_next;
    logic                        ref_hit;
    overlay_pkg::shade_t         gray_stage;
    overlay_pkg::shade_t         ref_gray;
    logic                        ref_red;
    logic                        gray_failed = 1'b0;
    logic                        red_failed = 1'b0;
    logic                        early_failed = 1'b0;
    logic                        any_failed;

    function automatic overlay_pkg::area_t box_area(input overlay_pkg::coord_t min_x,
                                                    input overlay_pkg::coord_t max_x,
                                                    input overlay_pkg::coord_t min_y,
                                                    input overlay_pkg::coord_t max_y);
        int w;
        int h;
        if (min_x == `OVL_EMPTY_COORD || min_y == `OVL_EMPTY_COORD ||
            max_x < min_x || max_y < min_y) begin
            return '0;
        end
        w = int'(max_x) - int'(min_x) + 1;
        h = int'(max_y) - int'(min_y) + 1;
        return overlay_pkg::area_t'(w * h);
    endfunction

    function automatic overlay_pkg::area_t area_limit(input logic [`OVL_THRESH_W-1:0] sw);
        if (sw == '0) begin
            return overlay_pkg::area_t'(`OVL_DEFAULT_AREA);
        end
        return overlay_pkg::area_t'(sw);
    endfunction

    function automatic logic on_border(input overlay_pkg::coord_t x, input overlay_pkg::coord_t y,
                                       input overlay_pkg::coord_t min_x,
                                       input overlay_pkg::coord_t max_x,
                                       input overlay_pkg::coord_t min_y,
                                       input overlay_pkg::coord_t max_y);
        logic span_x;
        logic span_y;
        span_x = (x >= min_x) && (x <= max_x);
        span_y = (y >= min_y) && (y <= max_y);
        return ((y == min_y || y == max_y) && span_x) || ((x == min_x || x == max_x) && span_y);
    endfunction

    function automatic overlay_pkg::shade_t scaled_gray(input logic [`OVL_PIX_W-1:0] pix,
                                                        input overlay_pkg::shade_t level);
        int unsigned prod;
        prod = int'(pix >> 1) * int'(level);
        return overlay_pkg::shade_t'(prod >> 7);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    assign end_of_vsync = vs_last & ~vs_sync;

    always_comb begin
        hit_next = 1'b0;
        for (int r = 0; r < `OVL_NUM_REGIONS; r++) begin
            valid_next[r] = box_area(ref_min_x[r], ref_max_x[r], ref_min_y[r], ref_max_y[r])
                            >= area_limit(area_thresh_i);
            if (ref_valid[r] && on_border(draw_x_i, draw_y_i, ref_min_x[r], ref_max_x[r],
                                          ref_min_y[r], ref_max_y[r])) begin
                hit_next = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vs_meta     <= 1'b0;
            vs_sync     <= 1'b0;
            vs_last     <= 1'b0;
            event_count <= 0;
            snap_taken  <= 1'b0;
            ref_min_x   <= {`OVL_NUM_REGIONS{overlay_pkg::coord_t'(`OVL_EMPTY_COORD)}};
            ref_min_y   <= {`OVL_NUM_REGIONS{overlay_pkg::coord_t'(`OVL_EMPTY_COORD)}};
            ref_max_x   <= '0;
            ref_max_y   <= '0;
            ref_valid   <= '0;
            ref_hit     <= 1'b0;
            gray_stage  <= '0;
            ref_gray    <= '0;
            ref_red     <= 1'b0;
        end else begin
            vs_meta <= vsync_i;
            vs_sync <= vs_meta;
            vs_last <= vs_sync;
            if (end_of_vsync && event_count == `OVL_SNAPSHOT_PERIOD - 1) begin
                event_count <= 0;
                snap_taken  <= 1'b1;
                ref_min_x   <= region_min_x_i;
                ref_max_x   <= region_max_x_i;
                ref_min_y   <= region_min_y_i;
                ref_max_y   <= region_max_y_i;
            end else if (end_of_vsync) begin
                event_count <= event_count + 1;
            end
            ref_valid  <= valid_next;
            ref_hit    <= hit_next;
            gray_stage <= scaled_gray(pixel_i, brightness_i);
            ref_gray   <= gray_stage;
            ref_red    <= ref_hit & highlight_i;
        end
    end

    assign any_failed = gray_failed | red_failed | early_failed;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    gray_path_a: assert property (@(posedge clk) disable iff (reset)
        !ref_red |-> (red_o == ref_gray && green_o == ref_gray && blue_o == ref_gray))
    else begin
        gray_failed = 1'b1;
        $error("CHECK FAILED red_o/green_o/blue_o=%h/%h/%h expected gray %h",
               $sampled(red_o), $sampled(green_o), $sampled(blue_o), $sampled(ref_gray));
    end

    outline_red_a: assert property (@(posedge clk) disable iff (reset)
        ref_red |-> (red_o == FULL_SHADE && green_o == '0 && blue_o == '0))
    else begin
        red_failed = 1'b1;
        $error("CHECK FAILED red_o/green_o/blue_o=%h/%h/%h expected %h/00/00",
               $sampled(red_o), $sampled(green_o), $sampled(blue_o), FULL_SHADE);
    end

    // Nothing red before the first snapshot
    no_early_box_a: assert property (@(posedge clk) disable iff (reset)
        !snap_taken |-> !(red_o == FULL_SHADE && green_o == '0 && blue_o == '0))
    else begin
        early_failed = 1'b1;
        $error("CHECK FAILED red_o/green_o/blue_o=%h/%h/%h before the first snapshot",
               $sampled(red_o), $sampled(green_o), $sampled(blue_o));
    end

endmodule

bind overlay_top overlay_assertions u_overlay_assertions (
    .clk            (clk),
    .reset          (reset),
    .vsync_i        (vsync_i),
    .region_min_x_i (region_min_x_i),
    .region_max_x_i (region_max_x_i),
    .region_min_y_i (region_min_y_i),
    .region_max_y_i (region_max_y_i),
    .draw_x_i       (draw_x_i),
    .draw_y_i       (draw_y_i),
    .pixel_i        (pixel_i),
    .brightness_i   (brightness_i),
    .area_thresh_i  (area_thresh_i),
    .highlight_i    (highlight_i),
    .red_o          (red_o),
    .green_o        (green_o),
    .blue_o         (blue_o)
);

/* dv/overlay_tb.sv */
`include "overlay_config.svh"

module overlay_tb;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 3;
    localparam int VSYNC_HIGH    = 4;
    localparam int VSYNC_LOW     = 4;
    localparam int VSYNC_EVENTS  = 15;
    localparam int SWEEP_CYCLES  = 3 * 26 * 14 + 2 * 12 * 12 + 3 * 6 * 6 + 5 * 5 + 11 * 11;
    localparam int RANDOM_CYCLES = 2 * 250;
    localparam int DRAIN_CYCLES  = 4;
    localparam int TEST_CYCLES   = RESET_CYCLES + VSYNC_EVENTS * (VSYNC_HIGH + VSYNC_LOW)
                                   + SWEEP_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES;

    logic                        clk;
    logic                        reset;
    logic                        vsync_i;
    overlay_pkg::region_coords_t region_min_x_i;
    overlay_pkg::region_coords_t region_max_x_i;
    overlay_pkg::region_coords_t region_min_y_i;
    overlay_pkg::region_coords_t region_max_y_i;
    overlay_pkg::coord_t         draw_x_i;
    overlay_pkg::coord_t         draw_y_i;
    logic [`OVL_PIX_W-1:0]       pixel_i;
    overlay_pkg::shade_t         brightness_i;
    logic [`OVL_THRESH_W-1:0]    area_thresh_i;
    logic                        highlight_i;
    overlay_pkg::shade_t         red_o;
    overlay_pkg::shade_t         green_o;
    overlay_pkg::shade_t         blue_o;

    overlay_top u_overlay_top (
        .clk            (clk),
        .reset          (reset),
        .vsync_i        (vsync_i),
        .region_min_x_i (region_min_x_i),
        .region_max_x_i (region_max_x_i),
        .region_min_y_i (region_min_y_i),
        .region_max_y_i (region_max_y_i),
        .draw_x_i       (draw_x_i),
        .draw_y_i       (draw_y_i),
        .pixel_i        (pixel_i),
        .brightness_i   (brightness_i),
        .area_thresh_i  (area_thresh_i),
        .highlight_i    (highlight_i),
        .red_o          (red_o),
        .green_o        (green_o),
        .blue_o         (blue_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("Simulation FAILED");
        $fatal(1, "%s", reason);
    endtask

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        stop_with_failure("Timeout: the stimulus did not finish in the expected time");
    end

    initial begin
        wait (u_overlay_top.u_overlay_assertions.any_failed);
        stop_with_failure("An overlay assertion fired");
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // New random pixel and level every cycle
    task automatic next_cycle();
        logic [31:0] word;
        @(negedge clk);
        word         = $urandom;
        pixel_i      = word[`OVL_PIX_W-1:0];
        brightness_i = overlay_pkg::shade_t'($urandom);
    endtask

    task automatic random_coords(input int cycles);
        repeat (cycles) begin
            next_cycle();
            draw_x_i = overlay_pkg::coord_t'($urandom_range(639, 0));
            draw_y_i = overlay_pkg::coord_t'($urandom_range(479, 0));
        end
    endtask

    task automatic pulse_vsync();
        next_cycle();
        vsync_i = 1'b1;
        repeat (VSYNC_HIGH - 1) next_cycle();
        next_cycle();
        vsync_i = 1'b0;
        repeat (VSYNC_LOW - 1) next_cycle();
    endtask

    task automatic clear_regions();
        region_min_x_i = {`OVL_NUM_REGIONS{overlay_pkg::coord_t'(`OVL_EMPTY_COORD)}};
        region_min_y_i = {`OVL_NUM_REGIONS{overlay_pkg::coord_t'(`OVL_EMPTY_COORD)}};
        region_max_x_i = '0;
        region_max_y_i = '0;
    endtask

    task automatic set_box(input int r, input int min_x, input int max_x,
                           input int min_y, input int max_y);
        region_min_x_i[r] = overlay_pkg::coord_t'(min_x);
        region_max_x_i[r] = overlay_pkg::coord_t'(max_x);
        region_min_y_i[r] = overlay_pkg::coord_t'(min_y);
        region_max_y_i[r] = overlay_pkg::coord_t'(max_y);
    endtask

    // Border, inside and a one pixel ring outside
    task automatic sweep_box(input int min_x, input int max_x, input int min_y, input int max_y);
        for (int y = min_y - 1; y <= max_y + 1; y++) begin
            for (int x = min_x - 1; x <= max_x + 1; x++) begin
                next_cycle();
                draw_x_i = overlay_pkg::coord_t'(x);
                draw_y_i = overlay_pkg::coord_t'(y);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(55));
        reset         = 1'b1;
        vsync_i       = 1'b0;
        draw_x_i      = '0;
        draw_y_i      = '0;
        pixel_i       = '0;
        brightness_i  = '0;
        area_thresh_i = '0;
        highlight_i   = 1'b1;
        clear_regions();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        random_coords(RANDOM_CYCLES / 2);

        // Large box held before the fifth event
        set_box(0, 100, 123, 60, 71);
        repeat (4) pulse_vsync();
        sweep_box(100, 123, 60, 71);
        pulse_vsync();
        sweep_box(100, 123, 60, 71);

        // Moved box shows up on the tenth event
        set_box(0, 300, 309, 200, 209);
        repeat (4) pulse_vsync();
        sweep_box(300, 309, 200, 209);
        sweep_box(100, 123, 60, 71);
        pulse_vsync();
        sweep_box(300, 309, 200, 209);
        random_coords(RANDOM_CYCLES / 2);

        // Area 9, area 16 and an empty region
        clear_regions();
        set_box(1, 200, 202, 100, 102);
        set_box(2, 220, 223, 100, 103);
        set_box(3, `OVL_EMPTY_COORD, 700, 120, 130);
        repeat (5) pulse_vsync();
        sweep_box(200, 202, 100, 102);
        sweep_box(220, 223, 100, 103);
        sweep_box(`OVL_EMPTY_COORD, 649, 121, 129);

        area_thresh_i = 20;
        sweep_box(220, 223, 100, 103);

        area_thresh_i = '0;
        highlight_i   = 1'b0;
        sweep_box(220, 223, 100, 103);
        repeat (DRAIN_CYCLES) next_cycle();

        if (u_overlay_top.u_overlay_assertions.any_failed) begin
            stop_with_failure("An overlay assertion fired before the end of the run");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the overlay testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module overlay_tb -f tb.f -o overlay_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

# Keep running after an assertion error so the testbench can report it
./obj_dir/overlay_sim +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    echo "Result: FAIL"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

echo "Result: PASS"
exit 0

/* tb.f */
+incdir+verilog
verilog/overlay_pkg.sv
verilog/box_snapshot.sv
verilog/box_area_filter.sv
verilog/box_outline.sv
verilog/pixel_shade.sv
verilog/overlay_top.sv
dv/overlay_assertions.sv
dv/overlay_tb.sv

/* verilog/box_area_filter.sv */
`include "overlay_config.svh"

module box_area_filter (
    input  logic                        clk,
    input  logic                        reset,
    input  overlay_pkg::region_coords_t snap_min_x_i,
    input  overlay_pkg::region_coords_t snap_max_x_i,
    input  overlay_pkg::region_coords_t snap_min_y_i,
    input  overlay_pkg::region_coords_t snap_max_y_i,
    input  logic [`OVL_THRESH_W-1:0]    area_thresh_i,
    output overlay_pkg::region_mask_t   region_valid_o
);

    logic [`OVL_COORD_W:0]     width  [`OVL_NUM_REGIONS];
    logic [`OVL_COORD_W:0]     height [`OVL_NUM_REGIONS];
    overlay_pkg::area_t        area   [`OVL_NUM_REGIONS];
    overlay_pkg::region_mask_t is_box;
    overlay_pkg::region_mask_t valid_d;
    overlay_pkg::area_t        thresh;

    // Zero on the switches selects the default
    assign thresh = (area_thresh_i != '0) ? overlay_pkg::area_t'(area_thresh_i)
                                          : overlay_pkg::area_t'(`OVL_DEFAULT_AREA);

    always_comb begin
        for (int r = 0; r < `OVL_NUM_REGIONS; r++) begin
            is_box[r] = (snap_min_x_i[r] != overlay_pkg::coord_t'(`OVL_EMPTY_COORD)) &&
                        (snap_min_y_i[r] != overlay_pkg::coord_t'(`OVL_EMPTY_COORD)) &&
                        (snap_max_x_i[r] >= snap_min_x_i[r]) &&
                        (snap_max_y_i[r] >= snap_min_y_i[r]);
            if (is_box[r]) begin
                width[r]  = {1'b0, snap_max_x_i[r]} - {1'b0, snap_min_x_i[r]} + 1'b1;
                height[r] = {1'b0, snap_max_y_i[r]} - {1'b0, snap_min_y_i[r]} + 1'b1;
                area[r]   = width[r] * height[r];
            end else begin
                width[r]  = '0;
                height[r] = '0;
                area[r]   = '0;
            end
            valid_d[r] = (area[r] >= thresh);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            region_valid_o <= '0;
        end else begin
            region_valid_o <= valid_d;
        end
    end

endmodule

/* verilog/box_outline.sv */
`include "overlay_config.svh"

module box_outline (
    input  logic                        clk,
    input  logic                        reset,
    input  overlay_pkg::coord_t         draw_x_i,
    input  overlay_pkg::coord_t         draw_y_i,
    input  overlay_pkg::region_coords_t snap_min_x_i,
    input  overlay_pkg::region_coords_t snap_max_x_i,
    input  overlay_pkg::region_coords_t snap_min_y_i,
    input  overlay_pkg::region_coords_t snap_max_y_i,
    input  overlay_pkg::region_mask_t   region_valid_i,
    output logic                        outline_hit_o
);

    overlay_pkg::region_mask_t in_x;
    overlay_pkg::region_mask_t in_y;
    overlay_pkg::region_mask_t on_h_edge;
    overlay_pkg::region_mask_t on_v_edge;
    overlay_pkg::region_mask_t region_hit;
    logic                      hit_d;

    //////////////////////////////////////////////////////////////////////
    // Per-region border test
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int r = 0; r < `OVL_NUM_REGIONS; r++) begin
            in_x[r] = (draw_x_i >= snap_min_x_i[r]) && (draw_x_i <= snap_max_x_i[r]);
            in_y[r] = (draw_y_i >= snap_min_y_i[r]) && (draw_y_i <= snap_max_y_i[r]);

            // Top or bottom row
            on_h_edge[r] = ((draw_y_i == snap_min_y_i[r]) || (draw_y_i == snap_max_y_i[r]))
                           && in_x[r];
            // Left or right column
            on_v_edge[r] = ((draw_x_i == snap_min_x_i[r]) || (draw_x_i == snap_max_x_i[r]))
                           && in_y[r];

            region_hit[r] = region_valid_i[r] && (on_h_edge[r] || on_v_edge[r]);
        end
    end

    // All boxes draw in the same colour
    assign hit_d = |region_hit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outline_hit_o <= 1'b0;
        end else begin
            outline_hit_o <= hit_d;
        end
    end

endmodule

/* verilog/box_snapshot.sv */
`include "overlay_config.svh"

module box_snapshot (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        vsync_i,
    input  overlay_pkg::region_coords_t min_x_i,
    input  overlay_pkg::region_coords_t max_x_i,
    input  overlay_pkg::region_coords_t min_y_i,
    input  overlay_pkg::region_coords_t max_y_i,
    output overlay_pkg::region_coords_t snap_min_x_o,
    output overlay_pkg::region_coords_t snap_max_x_o,
    output overlay_pkg::region_coords_t snap_min_y_o,
    output overlay_pkg::region_coords_t snap_max_y_o
);

    logic       vsync_meta;
    logic       vsync_sync;
    logic       vsync_prev;
    logic       vsync_end;
    logic [2:0] event_cnt;
    logic       take_snap;

    //////////////////////////////////////////////////////////////////////
    // Vsync synchronizer and falling edge detect
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vsync_meta <= 1'b0;
            vsync_sync <= 1'b0;
            vsync_prev <= 1'b0;
        end else begin
            vsync_meta <= vsync_i;
            vsync_sync <= vsync_meta;
            vsync_prev <= vsync_sync;
        end
    end

    // High then low on the synchronized line
    assign vsync_end = vsync_prev & ~vsync_sync;

    //////////////////////////////////////////////////////////////////////
    // Frame divider
    //////////////////////////////////////////////////////////////////////

    assign take_snap = vsync_end && (event_cnt == 3'(`OVL_SNAPSHOT_PERIOD - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            event_cnt <= '0;
        end else if (take_snap) begin
            event_cnt <= '0;
        end else if (vsync_end) begin
            event_cnt <= event_cnt + 3'd1;
        end
    end

    // Boxes start empty so nothing is drawn before the first snapshot
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            snap_min_x_o <= {`OVL_NUM_REGIONS{overlay_pkg::coord_t'(`OVL_EMPTY_COORD)}};
            snap_min_y_o <= {`OVL_NUM_REGIONS{overlay_pkg::coord_t'(`OVL_EMPTY_COORD)}};
            snap_max_x_o <= '0;
            snap_max_y_o <= '0;
        end else if (take_snap) begin
            snap_min_x_o <= min_x_i;
            snap_max_x_o <= max_x_i;
            snap_min_y_o <= min_y_i;
            snap_max_y_o <= max_y_i;
        end
    end

endmodule

/* verilog/overlay_config.svh */
`ifndef OVERLAY_CONFIG_SVH
`define OVERLAY_CONFIG_SVH

// 640x480 raster coordinates fit in 10 bits
`define OVL_COORD_W 10

// Tracker grid is 4 by 3
`define OVL_NUM_REGIONS 12

// Min field value for a region that saw no pixel
`define OVL_EMPTY_COORD 641

// End-of-vsync events per box snapshot
`define OVL_SNAPSHOT_PERIOD 5

// Area threshold when the switch word is zero
`define OVL_DEFAULT_AREA 16

`define OVL_PIX_W 8
`define OVL_SHADE_W 7
`define OVL_THRESH_W 15

`endif

/* verilog/overlay_pkg.sv */
`include "overlay_config.svh"

package overlay_pkg;

    // One raster coordinate
    typedef logic [`OVL_COORD_W-1:0] coord_t;

    // One coordinate per tracked region
    typedef coord_t [`OVL_NUM_REGIONS-1:0] region_coords_t;

    // Width and height are one bit wider than a coordinate
    typedef logic [2*(`OVL_COORD_W+1)-1:0] area_t;

    // One colour channel
    typedef logic [`OVL_SHADE_W-1:0] shade_t;

    // One flag per region
    typedef logic [`OVL_NUM_REGIONS-1:0] region_mask_t;

endpackage

/* verilog/overlay_top.sv */
`include "overlay_config.svh"

module overlay_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        vsync_i,
    input  overlay_pkg::region_coords_t region_min_x_i,
    input  overlay_pkg::region_coords_t region_max_x_i,
    input  overlay_pkg::region_coords_t region_min_y_i,
    input  overlay_pkg::region_coords_t region_max_y_i,
    input  overlay_pkg::coord_t         draw_x_i,
    input  overlay_pkg::coord_t         draw_y_i,
    input  logic [`OVL_PIX_W-1:0]       pixel_i,
    input  overlay_pkg::shade_t         brightness_i,
    input  logic [`OVL_THRESH_W-1:0]    area_thresh_i,
    input  logic                        highlight_i,
    output overlay_pkg::shade_t         red_o,
    output overlay_pkg::shade_t         green_o,
    output overlay_pkg::shade_t         blue_o
);

    overlay_pkg::region_coords_t snap_min_x;
    overlay_pkg::region_coords_t snap_max_x;
    overlay_pkg::region_coords_t snap_min_y;
    overlay_pkg::region_coords_t snap_max_y;
    overlay_pkg::region_mask_t   region_valid;
    logic                        outline_hit;

    // Boxes held between snapshots
    box_snapshot u_box_snapshot (
        .clk          (clk),
        .reset        (reset),
        .vsync_i      (vsync_i),
        .min_x_i      (region_min_x_i),
        .max_x_i      (region_max_x_i),
        .min_y_i      (region_min_y_i),
        .max_y_i      (region_max_y_i),
        .snap_min_x_o (snap_min_x),
        .snap_max_x_o (snap_max_x),
        .snap_min_y_o (snap_min_y),
        .snap_max_y_o (snap_max_y)
    );

    box_area_filter u_box_area_filter (
        .clk            (clk),
        .reset          (reset),
        .snap_min_x_i   (snap_min_x),
        .snap_max_x_i   (snap_max_x),
        .snap_min_y_i   (snap_min_y),
        .snap_max_y_i   (snap_max_y),
        .area_thresh_i  (area_thresh_i),
        .region_valid_o (region_valid)
    );

    box_outline u_box_outline (
        .clk            (clk),
        .reset          (reset),
        .draw_x_i       (draw_x_i),
        .draw_y_i       (draw_y_i),
        .snap_min_x_i   (snap_min_x),
        .snap_max_x_i   (snap_max_x),
        .snap_min_y_i   (snap_min_y),
        .snap_max_y_i   (snap_max_y),
        .region_valid_i (region_valid),
        .outline_hit_o  (outline_hit)
    );

    // Two-stage pixel path matching the outline delay
    pixel_shade u_pixel_shade (
        .clk           (clk),
        .reset         (reset),
        .pixel_i       (pixel_i),
        .brightness_i  (brightness_i),
        .outline_hit_i (outline_hit),
        .highlight_i   (highlight_i),
        .red_o         (red_o),
        .green_o       (green_o),
        .blue_o        (blue_o)
    );

endmodule

/* verilog/pixel_shade.sv */
`include "overlay_config.svh"

module pixel_shade (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`OVL_PIX_W-1:0] pixel_i,
    input  overlay_pkg::shade_t  brightness_i,
    input  logic                 outline_hit_i,
    input  logic                 highlight_i,
    output overlay_pkg::shade_t  red_o,
    output overlay_pkg::shade_t  green_o,
    output overlay_pkg::shade_t  blue_o
);

    logic [2*`OVL_SHADE_W-1:0] product;
    overlay_pkg::shade_t       gray_q;
    logic                      draw_red;

    // Upper pixel bits times level, then divide by 128
    assign product = pixel_i[`OVL_PIX_W-1 -: `OVL_SHADE_W] * brightness_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gray_q <= '0;
        end else begin
            gray_q <= product[2*`OVL_SHADE_W-1 -: `OVL_SHADE_W];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Colour mix
    //////////////////////////////////////////////////////////////////////

    assign draw_red = outline_hit_i & highlight_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            red_o   <= '0;
            green_o <= '0;
            blue_o  <= '0;
        end else if (draw_red) begin
            red_o   <= '1;
            green_o <= '0;
            blue_o  <= '0;
        end else begin
            red_o   <= gray_q;
            green_o <= gray_q;
            blue_o  <= gray_q;
        end
    end

endmodule
